/* all.f */
verilog/mci_pkg.sv
verilog/mci_bus_decode.sv
verilog/mci_sram_arb.sv
verilog/mci_sram.sv
verilog/mci_wdt.sv
verilog/mci_reg_bank.sv
verilog/mci_top.sv
testbench/tb_clk_gen.sv
testbench/mci_top_tb.sv

/* testbench/mci_top_tb.sv */
`timescale 1ns/1ps

module mci_top_tb import mci_pkg::*; ();

    localparam int SRAM_WORDS = 1024;
    localparam int WDT_OUT    = 0;
    localparam int NMI_OUT    = 1;
    localparam int FATAL_OUT  = 2;

    logic              clk;
    logic              arst_n;
    bus_req_t          bus_req_i;
    bus_rsp_t          bus_rsp_o;
    dmi_req_t          dmi_req_i;
    bus_rsp_t          dmi_rsp_o;
    logic [DATA_W-1:0] agg_error_fatal_i;
    logic              all_error_fatal_o;
    logic              wdt_timeout_o;
    logic              nmi_intr_o;
    integer            seed;

    tb_clk_gen u_clk_gen (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    mci_top #(
        .SRAM_DEPTH_WORDS(SRAM_WORDS)
    ) u_mci_top (
        .clk               (clk),
        .arst_n_i          (arst_n),
        .bus_req_i         (bus_req_i),
        .bus_rsp_o         (bus_rsp_o),
        .dmi_req_i         (dmi_req_i),
        .dmi_rsp_o         (dmi_rsp_o),
        .agg_error_fatal_i (agg_error_fatal_i),
        .all_error_fatal_o (all_error_fatal_o),
        .wdt_timeout_o     (wdt_timeout_o),
        .nmi_intr_o        (nmi_intr_o)
    );

    //////////////////////////////
    // Checking helpers
    //////////////////////////////
    task automatic abort_run();
        $display("SOME TESTS FAILED");
        $fatal(1);
    endtask

    task automatic check(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("error: %s = 0x%h, expected 0x%h", name, got, exp);
            abort_run();
        end
    endtask

    task automatic check_range(input string what, input int val, input int lo, input int hi);
        if (val < lo || val > hi) begin
            $display("%s took %0d cycles, allowed %0d to %0d", what, val, lo, hi);
            abort_run();
        end
    endtask

    function automatic logic out_level(input int which);
        case (which)
            WDT_OUT: return wdt_timeout_o;
            NMI_OUT: return nmi_intr_o;
            default: return all_error_fatal_o;
        endcase
    endfunction

    function automatic string out_name(input int which);
        case (which)
            WDT_OUT: return "wdt_timeout_o";
            NMI_OUT: return "nmi_intr_o";
            default: return "all_error_fatal_o";
        endcase
    endfunction

    // Counts falling edges until the output reaches the level
    task automatic wait_output(input int which, input logic level, input int limit,
                               output int cycles);
        cycles = 0;
        while (out_level(which) !== level) begin
            if (cycles >= limit) begin
                $display("%s did not go to %0b within %0d cycles", out_name(which), level, limit);
                abort_run();
            end
            @(negedge clk);
            cycles++;
        end
    endtask

    //////////////////////////////
    // Bus and DMI drivers
    //////////////////////////////
    task automatic bus_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
                              output logic [31:0] rdata, output logic err);
        int lat;
        @(posedge clk);
        #1;
        bus_req_i.valid = 1'b1;
        bus_req_i.write = wr;
        bus_req_i.addr  = addr;
        bus_req_i.wdata = wdata;
        lat = 0;
        @(negedge clk);
        while (!bus_rsp_o.valid) begin
            if (lat >= 8) begin
                $display("no bus response within 8 cycles for address %h", addr);
                abort_run();
            end
            @(posedge clk);
            #1;
            bus_req_i = '0;
            lat++;
            @(negedge clk);
        end
        check("bus_rsp_o latency", lat, 2);
        rdata = bus_rsp_o.rdata;
        err   = bus_rsp_o.err;
    endtask

    task automatic dmi_access(input logic wr, input logic [15:0] word, input logic [31:0] wdata,
                              output logic [31:0] rdata);
        int lat;
        @(posedge clk);
        #1;
        dmi_req_i.valid = 1'b1;
        dmi_req_i.write = wr;
        dmi_req_i.addr  = word;
        dmi_req_i.wdata = wdata;
        lat = 0;
        @(negedge clk);
        while (!dmi_rsp_o.valid) begin
            if (lat >= 8) begin
                $display("no DMI response within 8 cycles for word %h", word);
                abort_run();
            end
            @(posedge clk);
            #1;
            dmi_req_i = '0;
            lat++;
            @(negedge clk);
        end
        check("dmi_rsp_o latency", lat, 1);
        check("dmi_rsp_o.err", dmi_rsp_o.err, 1'b0);
        rdata = dmi_rsp_o.rdata;
    endtask

    task automatic reg_write(input logic [REG_OFF_W-1:0] off, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, REG_BASE + {off, 2'b00}, data, rdata, err);
        check("bus_rsp_o.err", err, 1'b0);
    endtask

    task automatic reg_read(input logic [REG_OFF_W-1:0] off, output logic [31:0] data);
        logic err;
        bus_access(1'b0, REG_BASE + {off, 2'b00}, '0, data, err);
        check("bus_rsp_o.err", err, 1'b0);
    endtask

    task automatic sram_write(input logic [9:0] word, input logic [31:0] data);
        logic [31:0] rdata;
        logic        err;
        bus_access(1'b1, SRAM_BASE + {word, 2'b00}, data, rdata, err);
        check("bus_rsp_o.err", err, 1'b0);
    endtask

    task automatic sram_read(input logic [9:0] word, output logic [31:0] data);
        logic err;
        bus_access(1'b0, SRAM_BASE + {word, 2'b00}, '0, data, err);
        check("bus_rsp_o.err", err, 1'b0);
    endtask

    //////////////////////////////
    // Directed tests
    //////////////////////////////
    // Back-to-back writes, then back-to-back reads
    task automatic sram_bus_rw();
        logic [9:0]  addrs [8];
        logic [31:0] data  [8];
        // Low bits carry the index so the words stay distinct
        for (int i = 0; i < 8; i++) begin
            addrs[i] = ($random(seed) & 32'h3f8) | i;
            data[i]  = $random(seed);
        end
        for (int pass = 0; pass < 2; pass++) begin
            for (int c = 0; c < 10; c++) begin
                @(posedge clk);
                #1;
                bus_req_i = '0;
                if (c < 8) begin
                    bus_req_i.valid = 1'b1;
                    bus_req_i.write = (pass == 0);
                    bus_req_i.addr  = SRAM_BASE + {addrs[c], 2'b00};
                    bus_req_i.wdata = data[c];
                end
                @(negedge clk);
                if (c < 2) begin
                    check("bus_rsp_o.valid", bus_rsp_o.valid, 1'b0);
                end else begin
                    check("bus_rsp_o.valid", bus_rsp_o.valid, 1'b1);
                    check("bus_rsp_o.err", bus_rsp_o.err, 1'b0);
                    if (pass == 1) begin
                        check("bus_rsp_o.rdata", bus_rsp_o.rdata, data[c-2]);
                    end
                end
            end
        end
    endtask

    task automatic sram_dmi_mapping();
        logic [9:0]  word;
        logic [31:0] val;
        logic [31:0] rdata;
        logic        err;
        word = $random(seed);
        val  = $random(seed);
        dmi_access(1'b1, word, val, rdata);
        sram_read(word, rdata);
        check("bus_rsp_o.rdata", rdata, val);
        word = $random(seed);
        val  = $random(seed);
        sram_write(word, val);
        dmi_access(1'b0, word, '0, rdata);
        check("dmi_rsp_o.rdata", rdata, val);
        // Outside both windows
        bus_access(1'b0, 32'h3000_0000, '0, rdata, err);
        check("bus_rsp_o.err", err, 1'b1);
        check("bus_rsp_o.rdata", rdata, 32'h0);
    endtask

    task automatic dmi_collision();
        logic [9:0]  word;
        logic [31:0] bus_val;
        logic [31:0] rdata;
        word    = $random(seed);
        bus_val = $random(seed);
        for (int c = 0; c < 4; c++) begin
            @(posedge clk);
            #1;
            bus_req_i = '0;
            dmi_req_i = '0;
            if (c == 0) begin
                bus_req_i.valid = 1'b1;
                bus_req_i.write = 1'b1;
                bus_req_i.addr  = SRAM_BASE + {word, 2'b00};
                bus_req_i.wdata = bus_val;
            end else if (c == 1) begin
                dmi_req_i.valid = 1'b1;
                dmi_req_i.write = 1'b1;
                dmi_req_i.addr  = word;
                dmi_req_i.wdata = ~bus_val;
            end
            @(negedge clk);
            check("dmi_rsp_o.valid", dmi_rsp_o.valid, 1'b0);
            if (c == 2) begin
                check("bus_rsp_o.valid", bus_rsp_o.valid, 1'b1);
            end
        end
        sram_read(word, rdata);
        check("sram word after collision", rdata, bus_val);
        reg_read(REG_STATUS, rdata);
        check("REG_STATUS[0]", rdata[0], 1'b1);
        reg_write(REG_STATUS, 32'h1);
        reg_read(REG_STATUS, rdata);
        check("REG_STATUS[0]", rdata[0], 1'b0);
    endtask

    task automatic wdt_cascade();
        int          n;
        logic [31:0] rdata;
        reg_write(REG_WDT_PERIOD1, 32'd20);
        reg_write(REG_WDT_PERIOD2, 32'd30);
        reg_write(REG_WDT_CTRL, 32'h1);
        // The enabling strobe was two cycles ago
        wait_output(WDT_OUT, 1'b1, 40, n);
        check_range("wdt_timeout_o rise after enable", n + 2, 20, 24);
        wait_output(NMI_OUT, 1'b1, 50, n);
        check_range("nmi_intr_o rise after timer 1", n, 30, 34);
        reg_read(REG_STATUS, rdata);
        check("REG_STATUS[2:0]", rdata[2:0], 3'b110);
        // Restart with enable cleared
        reg_write(REG_WDT_CTRL, 32'h2);
        wait_output(WDT_OUT, 1'b0, 4, n);
        wait_output(NMI_OUT, 1'b0, 4, n);
        reg_read(REG_STATUS, rdata);
        check("REG_STATUS[2:0]", rdata[2:0], 3'b000);
    endtask

    task automatic fatal_capture();
        int          n;
        logic [31:0] bit_mask;
        logic [31:0] rdata;
        bit_mask = 32'h1 << ($random(seed) & 31);
        @(posedge clk);
        #1;
        agg_error_fatal_i = bit_mask;
        @(posedge clk);
        #1;
        agg_error_fatal_i = '0;
        @(negedge clk);
        wait_output(FATAL_OUT, 1'b1, 4, n);
        reg_read(REG_ERR_FATAL, rdata);
        check("REG_ERR_FATAL", rdata, bit_mask);
        reg_write(REG_ERR_MASK, bit_mask);
        wait_output(FATAL_OUT, 1'b0, 4, n);
        reg_write(REG_ERR_MASK, 32'h0);
        wait_output(FATAL_OUT, 1'b1, 4, n);
        reg_write(REG_ERR_FATAL, bit_mask);
        wait_output(FATAL_OUT, 1'b0, 4, n);
        // Sticky bit gone, so it must not come back
        repeat (5) begin
            @(negedge clk);
            check("all_error_fatal_o", all_error_fatal_o, 1'b0);
        end
        reg_read(REG_ERR_FATAL, rdata);
        check("REG_ERR_FATAL", rdata, 32'h0);
    endtask

    //////////////////////////////
    // Test sequence
    //////////////////////////////
    initial begin
        int n;
        seed              = 32'hd80d;
        bus_req_i         = '0;
        dmi_req_i         = '0;
        agg_error_fatal_i = '0;
        n = 0;
        while (arst_n !== 1'b1) begin
            if (n >= 10) begin
                $display("reset was not released within 10 cycles");
                abort_run();
            end
            @(posedge clk);
            n++;
        end
        @(negedge clk);
        check("bus_rsp_o.valid", bus_rsp_o.valid, 1'b0);
        check("dmi_rsp_o.valid", dmi_rsp_o.valid, 1'b0);
        check("wdt_timeout_o", wdt_timeout_o, 1'b0);
        check("nmi_intr_o", nmi_intr_o, 1'b0);
        check("all_error_fatal_o", all_error_fatal_o, 1'b0);

        sram_bus_rw();
        sram_dmi_mapping();
        dmi_collision();
        wdt_cascade();
        fatal_capture();

        $display("ALL TESTS PASSED");
        $finish;
    end

endmodule

/* testbench/tb_clk_gen.sv */
`timescale 1ns/1ps

module tb_clk_gen #(
    parameter int PERIOD_NS  = 10,
    parameter int RST_CYCLES = 3
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial begin
        clk_o = 1'b0;
        forever begin
            #(PERIOD_NS / 2);
            clk_o = ~clk_o;
        end
    end

    // Release just after an edge
    initial begin
        arst_n_o = 1'b0;
        repeat (RST_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;
    end

endmodule

/* verilog/mci_bus_decode.sv */
`timescale 1ns/1ps

module mci_bus_decode import mci_pkg::*; #(
    parameter int SRAM_DEPTH_WORDS = 1024
) (
    input  logic      clk,
    input  logic      arst_n_i,
    input  bus_req_t  bus_req_i,
    output bus_req_t  reg_req_o,
    output sram_req_t sram_req_o,
    input  bus_rsp_t  reg_rsp_i,
    input  bus_rsp_t  sram_rsp_i,
    output bus_rsp_t  bus_rsp_o
);

    localparam logic [ADDR_W-1:0] SRAM_BYTES = ADDR_W'(SRAM_DEPTH_WORDS * 4);

    bus_req_t          req_q;
    logic              err_q;
    logic              in_reg;
    logic              in_sram;
    logic [ADDR_W-1:0] reg_off;
    logic [ADDR_W-1:0] sram_off;

    // Request stage, then a delayed error for unmapped accesses
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            req_q <= '0;
            err_q <= 1'b0;
        end else begin
            req_q <= bus_req_i;
            err_q <= req_q.valid & ~in_reg & ~in_sram;
        end
    end

    // Window decode on the registered address
    assign reg_off  = req_q.addr - REG_BASE;
    assign sram_off = req_q.addr - SRAM_BASE;
    assign in_reg   = (req_q.addr >= REG_BASE) && (reg_off < REG_WIN_BYTES);
    assign in_sram  = (req_q.addr >= SRAM_BASE) && (sram_off < SRAM_BYTES);

    // Register bank sees a window-relative byte address
    assign reg_req_o = '{valid: req_q.valid & in_reg, write: req_q.write,
                         addr: reg_off, wdata: req_q.wdata};

    // SRAM takes word indices
    assign sram_req_o = '{valid: req_q.valid & in_sram, write: req_q.write,
                          addr: sram_off[DMI_ADDR_W+1:2], wdata: req_q.wdata};

    // Merge the three response sources
    always_comb begin
        bus_rsp_o = '0;
        if (reg_rsp_i.valid) begin
            bus_rsp_o = reg_rsp_i;
        end else if (sram_rsp_i.valid) begin
            bus_rsp_o = sram_rsp_i;
        end else if (err_q) begin
            bus_rsp_o.valid = 1'b1;
            bus_rsp_o.err   = 1'b1;
        end
    end

    a_rsp_mutex: assert property (@(posedge clk) disable iff (!arst_n_i)
        $onehot0({reg_rsp_i.valid, sram_rsp_i.valid, err_q}));

    // Every strobe gets its answer two cycles later
    a_rsp_latency: assert property (@(posedge clk) disable iff (!arst_n_i)
        bus_req_i.valid |-> ##2 bus_rsp_o.valid);

endmodule

/* verilog/mci_pkg.sv */
package mci_pkg;

    //////////////////////////////
    // Widths
    //////////////////////////////
    localparam int DATA_W     = 32;
    localparam int ADDR_W     = 32;
    localparam int DMI_ADDR_W = 16;

    //////////////////////////////
    // Address map
    //////////////////////////////
    localparam logic [ADDR_W-1:0] REG_BASE  = 32'h1000_0000;
    localparam logic [ADDR_W-1:0] SRAM_BASE = 32'h2000_0000;

    // Register window holds 2**REG_OFF_W words
    localparam int                REG_OFF_W     = 4;
    localparam logic [ADDR_W-1:0] REG_WIN_BYTES = ADDR_W'(4 << REG_OFF_W);

    // Word offsets inside the register window
    localparam logic [REG_OFF_W-1:0] REG_STATUS      = 4'h0;
    localparam logic [REG_OFF_W-1:0] REG_WDT_CTRL    = 4'h1;
    localparam logic [REG_OFF_W-1:0] REG_WDT_PERIOD1 = 4'h2;
    localparam logic [REG_OFF_W-1:0] REG_WDT_PERIOD2 = 4'h3;
    localparam logic [REG_OFF_W-1:0] REG_ERR_FATAL   = 4'h4;
    localparam logic [REG_OFF_W-1:0] REG_ERR_MASK    = 4'h5;

    //////////////////////////////
    // Transfer types
    //////////////////////////////
    typedef struct packed {
        logic              valid;
        logic              write;
        logic [ADDR_W-1:0] addr;
        logic [DATA_W-1:0] wdata;
    } bus_req_t;

    typedef struct packed {
        logic              valid;
        logic              err;
        logic [DATA_W-1:0] rdata;
    } bus_rsp_t;

    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [DMI_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } dmi_req_t;

    // Arbitrated memory port, word addressed
    typedef struct packed {
        logic                  valid;
        logic                  write;
        logic [DMI_ADDR_W-1:0] addr;
        logic [DATA_W-1:0]     wdata;
    } sram_req_t;

    typedef struct packed {
        logic              en;
        logic              restart;
        logic [DATA_W-1:0] period1;
        logic [DATA_W-1:0] period2;
    } wdt_cfg_t;

    typedef struct packed {
        logic t1_timeout;
        logic t2_timeout;
    } wdt_status_t;

endpackage

/* verilog/mci_reg_bank.sv */
`timescale 1ns/1ps

module mci_reg_bank import mci_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  bus_req_t          req_i,
    output bus_rsp_t          rsp_o,
    input  logic              collision_i,
    input  wdt_status_t       wdt_status_i,
    input  logic [DATA_W-1:0] agg_error_fatal_i,
    output wdt_cfg_t          wdt_cfg_o,
    output logic              all_error_fatal_o
);

    logic [REG_OFF_W-1:0] off;
    logic                 wr;
    logic                 rd;
    logic [DATA_W-1:0]    rd_val;

    logic                 coll_q;
    logic                 wdt_en_q;
    logic                 restart_q;
    logic [DATA_W-1:0]    period1_q;
    logic [DATA_W-1:0]    period2_q;
    logic [DATA_W-1:0]    err_fatal_q;
    logic [DATA_W-1:0]    err_mask_q;
    logic                 fatal_q;
    bus_rsp_t             rsp_q;

    // Word offset from the window-relative address
    assign off = req_i.addr[REG_OFF_W+1:2];
    assign wr  = req_i.valid & req_i.write;
    assign rd  = req_i.valid & ~req_i.write;

    //////////////////////////////
    // Write decode
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            coll_q    <= 1'b0;
            wdt_en_q  <= 1'b0;
            restart_q <= 1'b0;
            period1_q <= '0;
            period2_q <= '0;
            err_mask_q <= '0;
        end else begin
            // Restart lives for one cycle only
            restart_q <= wr && (off == REG_WDT_CTRL) && req_i.wdata[1];

            // New collision beats a clear in the same cycle
            if (collision_i) begin
                coll_q <= 1'b1;
            end else if (wr && (off == REG_STATUS) && req_i.wdata[0]) begin
                coll_q <= 1'b0;
            end

            if (wr && (off == REG_WDT_CTRL)) begin
                wdt_en_q <= req_i.wdata[0];
            end
            if (wr && (off == REG_WDT_PERIOD1)) begin
                period1_q <= req_i.wdata;
            end
            if (wr && (off == REG_WDT_PERIOD2)) begin
                period2_q <= req_i.wdata;
            end
            if (wr && (off == REG_ERR_MASK)) begin
                err_mask_q <= req_i.wdata;
            end
        end
    end

    //////////////////////////////
    // Fatal error capture
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            err_fatal_q <= '0;
            fatal_q     <= 1'b0;
        end else begin
            // An error arriving during a W1C write stays set
            if (wr && (off == REG_ERR_FATAL)) begin
                err_fatal_q <= (err_fatal_q & ~req_i.wdata) | agg_error_fatal_i;
            end else begin
                err_fatal_q <= err_fatal_q | agg_error_fatal_i;
            end
            fatal_q <= |(err_fatal_q & ~err_mask_q);
        end
    end

    assign all_error_fatal_o = fatal_q;

    //////////////////////////////
    // Read path
    //////////////////////////////
    always_comb begin
        case (off)
            REG_STATUS: rd_val = {{(DATA_W-3){1'b0}}, wdt_status_i.t2_timeout,
                                  wdt_status_i.t1_timeout, coll_q};
            REG_WDT_CTRL:    rd_val = {{(DATA_W-1){1'b0}}, wdt_en_q};
            REG_WDT_PERIOD1: rd_val = period1_q;
            REG_WDT_PERIOD2: rd_val = period2_q;
            REG_ERR_FATAL:   rd_val = err_fatal_q;
            REG_ERR_MASK:    rd_val = err_mask_q;
            default:         rd_val = '0;
        endcase
    end

    // Answer every access one cycle later, writes included
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_q <= '0;
        end else begin
            rsp_q.valid <= req_i.valid;
            rsp_q.err   <= 1'b0;
            rsp_q.rdata <= rd ? rd_val : '0;
        end
    end

    assign rsp_o = rsp_q;

    assign wdt_cfg_o.en      = wdt_en_q;
    assign wdt_cfg_o.restart = restart_q;
    assign wdt_cfg_o.period1 = period1_q;
    assign wdt_cfg_o.period2 = period2_q;

endmodule

/* verilog/mci_sram.sv */
`timescale 1ns/1ps

module mci_sram import mci_pkg::*; #(
    parameter int SRAM_DEPTH_WORDS = 1024
) (
    input  logic              clk,
    input  sram_req_t         mem_req_i,
    output logic [DATA_W-1:0] rdata_o
);

    localparam int IDX_W = $clog2(SRAM_DEPTH_WORDS);

    logic [DATA_W-1:0] mem [SRAM_DEPTH_WORDS];
    logic [IDX_W-1:0]  idx;

    // Upper word address bits are outside the array
    assign idx = mem_req_i.addr[IDX_W-1:0];

    // Synchronous write, registered read
    always_ff @(posedge clk) begin
        if (mem_req_i.valid) begin
            if (mem_req_i.write) begin
                mem[idx] <= mem_req_i.wdata;
            end else begin
                rdata_o <= mem[idx];
            end
        end
    end

endmodule

/* verilog/mci_sram_arb.sv */
`timescale 1ns/1ps

module mci_sram_arb import mci_pkg::*; (
    input  logic              clk,
    input  logic              arst_n_i,
    input  sram_req_t         bus_req_i,
    input  dmi_req_t          dmi_req_i,
    output sram_req_t         mem_req_o,
    input  logic [DATA_W-1:0] mem_rdata_i,
    output bus_rsp_t          bus_rsp_o,
    output bus_rsp_t          dmi_rsp_o,
    output logic              collision_o
);

    logic bus_gnt;
    logic dmi_gnt;
    logic bus_gnt_q;
    logic dmi_gnt_q;
    logic rd_q;

    //////////////////////////////
    // Fixed priority with the bus first
    //////////////////////////////
    assign bus_gnt     = bus_req_i.valid;
    assign dmi_gnt     = dmi_req_i.valid & ~bus_req_i.valid;
    // DMI access dropped this cycle
    assign collision_o = dmi_req_i.valid & bus_req_i.valid;

    always_comb begin
        if (bus_gnt) begin
            mem_req_o = bus_req_i;
        end else begin
            mem_req_o.valid = dmi_gnt;
            mem_req_o.write = dmi_req_i.write;
            mem_req_o.addr  = dmi_req_i.addr;
            mem_req_o.wdata = dmi_req_i.wdata;
        end
    end

    // Which side owns the data coming back next cycle
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            bus_gnt_q <= 1'b0;
            dmi_gnt_q <= 1'b0;
            rd_q      <= 1'b0;
        end else begin
            bus_gnt_q <= bus_gnt;
            dmi_gnt_q <= dmi_gnt;
            rd_q      <= mem_req_o.valid & ~mem_req_o.write;
        end
    end

    //////////////////////////////
    // Response steering
    //////////////////////////////
    // Writes answer with zero data
    assign bus_rsp_o.valid = bus_gnt_q;
    assign bus_rsp_o.err   = 1'b0;
    assign bus_rsp_o.rdata = (bus_gnt_q & rd_q) ? mem_rdata_i : '0;

    assign dmi_rsp_o.valid = dmi_gnt_q;
    assign dmi_rsp_o.err   = 1'b0;
    assign dmi_rsp_o.rdata = (dmi_gnt_q & rd_q) ? mem_rdata_i : '0;

    a_rsp_excl: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(bus_rsp_o.valid && dmi_rsp_o.valid));

endmodule

/* verilog/mci_top.sv */
`timescale 1ns/1ps

module mci_top import mci_pkg::*; #(
    parameter int SRAM_DEPTH_WORDS = 1024
) (
    input  logic              clk,
    input  logic              arst_n_i,
    input  bus_req_t          bus_req_i,
    output bus_rsp_t          bus_rsp_o,
    input  dmi_req_t          dmi_req_i,
    output bus_rsp_t          dmi_rsp_o,
    input  logic [DATA_W-1:0] agg_error_fatal_i,
    output logic              all_error_fatal_o,
    output logic              wdt_timeout_o,
    output logic              nmi_intr_o
);

    bus_req_t          reg_req;
    bus_rsp_t          reg_rsp;
    sram_req_t         sram_bus_req;
    bus_rsp_t          sram_bus_rsp;
    sram_req_t         mem_req;
    logic [DATA_W-1:0] mem_rdata;
    logic              collision;
    wdt_cfg_t          wdt_cfg;
    wdt_status_t       wdt_status;

    //////////////////////////////
    // Bus decode and SRAM path
    //////////////////////////////
    mci_bus_decode #(
        .SRAM_DEPTH_WORDS(SRAM_DEPTH_WORDS)
    ) u_bus_decode (
        .clk        (clk),
        .arst_n_i   (arst_n_i),
        .bus_req_i  (bus_req_i),
        .reg_req_o  (reg_req),
        .sram_req_o (sram_bus_req),
        .reg_rsp_i  (reg_rsp),
        .sram_rsp_i (sram_bus_rsp),
        .bus_rsp_o  (bus_rsp_o)
    );

    mci_sram_arb u_sram_arb (
        .clk         (clk),
        .arst_n_i    (arst_n_i),
        .bus_req_i   (sram_bus_req),
        .dmi_req_i   (dmi_req_i),
        .mem_req_o   (mem_req),
        .mem_rdata_i (mem_rdata),
        .bus_rsp_o   (sram_bus_rsp),
        .dmi_rsp_o   (dmi_rsp_o),
        .collision_o (collision)
    );

    mci_sram #(
        .SRAM_DEPTH_WORDS(SRAM_DEPTH_WORDS)
    ) u_sram (
        .clk       (clk),
        .mem_req_i (mem_req),
        .rdata_o   (mem_rdata)
    );

    //////////////////////////////
    // CSRs and watchdog
    //////////////////////////////
    mci_reg_bank u_reg_bank (
        .clk               (clk),
        .arst_n_i          (arst_n_i),
        .req_i             (reg_req),
        .rsp_o             (reg_rsp),
        .collision_i       (collision),
        .wdt_status_i      (wdt_status),
        .agg_error_fatal_i (agg_error_fatal_i),
        .wdt_cfg_o         (wdt_cfg),
        .all_error_fatal_o (all_error_fatal_o)
    );

    mci_wdt u_wdt (
        .clk      (clk),
        .arst_n_i (arst_n_i),
        .cfg_i    (wdt_cfg),
        .status_o (wdt_status),
        .nmi_o    (nmi_intr_o)
    );

    assign wdt_timeout_o = wdt_status.t1_timeout;

endmodule

/* verilog/mci_wdt.sv */
`timescale 1ns/1ps

module mci_wdt import mci_pkg::*; (
    input  logic        clk,
    input  logic        arst_n_i,
    input  wdt_cfg_t    cfg_i,
    output wdt_status_t status_o,
    output logic        nmi_o
);

    logic [DATA_W-1:0] cnt1_q;
    logic [DATA_W-1:0] cnt2_q;
    logic              t1_q;
    logic              t2_q;

    //////////////////////////////
    // Timer 1
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt1_q <= '0;
            t1_q   <= 1'b0;
        end else if (cfg_i.restart) begin
            cnt1_q <= '0;
            t1_q   <= 1'b0;
        end else if (cfg_i.en && !t1_q) begin
            // Counter holds once the timeout is flagged
            if (cnt1_q >= cfg_i.period1) begin
                t1_q <= 1'b1;
            end else begin
                cnt1_q <= cnt1_q + 1'b1;
            end
        end
    end

    //////////////////////////////
    // Timer 2 armed by timer 1
    //////////////////////////////
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            cnt2_q <= '0;
            t2_q   <= 1'b0;
        end else if (cfg_i.restart) begin
            cnt2_q <= '0;
            t2_q   <= 1'b0;
        end else if (cfg_i.en && t1_q && !t2_q) begin
            if (cnt2_q >= cfg_i.period2) begin
                t2_q <= 1'b1;
            end else begin
                cnt2_q <= cnt2_q + 1'b1;
            end
        end
    end

    assign status_o.t1_timeout = t1_q;
    assign status_o.t2_timeout = t2_q;

    // Second stage expiry is fatal
    assign nmi_o = t2_q;

    a_nmi_after_t1: assert property (@(posedge clk) disable iff (!arst_n_i)
        nmi_o |-> status_o.t1_timeout);

endmodule
